// File: dv/rob_patterns.hex
// ctl(flush,alloc_valid,type0,type1,alu_valid,alu_idx0,alu_idx1,redirect) mem(valid,idx,load,excp,ecode[2])
// alloc_pc0 operand | exp flags(alloc_ready,mem_wb_ready,cmt_valid) exp_pc0 exp_aux0 exp_pc1 exp_aux1
03000000 00000000 00001000 00000000 11000000 00000000 00000000 00000000 00000000
00003010 00000000 00000000 000000a0 11000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 11300000 00001000 000000a0 00001004 000000a0
03000000 00000000 00002000 00000000 10000000 00000000 00000000 00000000 00000000
00001300 00000000 00000000 000000b3 10000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 10000000 00000000 00000000 00000000 00000000
00002020 00000000 00000000 000000b2 10000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 10300000 00002000 000000b2 00002004 000000b3
03010000 00000000 00003000 00000000 10000000 00000000 00000000 00000000 00000000
00003452 00000000 00000000 00005000 10000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 10100000 00003000 00005000 00000000 00000000
00000000 00000000 00000000 00000000 10100000 00003004 00005000 00000000 00000000
03110000 00000000 00004000 00000000 10000000 00000000 00000000 00000000 00000000
00003670 00000000 00000000 00004100 10000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 10100000 00004000 00004100 00000000 00000000
00000000 00000000 00000000 00000000 10100000 00004004 00004100 00000000 00000000
03030000 00000000 00005000 00000000 10000000 00000000 00000000 00000000 00000000
00000000 19000000 00000000 00008040 10000000 00000000 00000000 00000000 00000000
00001800 19000000 00000000 00008040 10000000 00000000 00000000 00000000 00000000
00000000 19000000 00000000 00008040 10100000 00005000 00008040 00000000 00000000
00000000 19000000 00000000 00008040 11000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 10100000 00005004 00000201 00000000 00000000
01200000 00000000 00006000 00000000 10000000 00000000 00000000 00000000 00000000
00000000 1a110500 00000000 12345678 11000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 10100000 00006000 1448d159 00000000 00000000
03000000 00000000 00007000 00000000 10000000 00000000 00000000 00000000 00000000
03000000 00000000 00007008 00000000 10000000 00000000 00000000 00000000 00000000
03000000 00000000 00007010 00000000 10000000 00000000 00000000 00000000 00000000
03000000 00000000 00007018 00000000 10000000 00000000 00000000 00000000 00000000
03000000 00000000 00007020 00000000 10000000 00000000 00000000 00000000 00000000
03000000 00000000 00007028 00000000 10000000 00000000 00000000 00000000 00000000
03000000 00000000 00007030 00000000 10000000 00000000 00000000 00000000 00000000
01000000 00000000 00007038 00000000 10000000 00000000 00000000 00000000 00000000
03000000 00000000 00007040 00000000 00000000 00000000 00000000 00000000 00000000
10000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 11000000 00000000 00000000 00000000 00000000

// File: rob.f
+incdir+logic
logic/rob_pkg.sv
logic/rob_queue_ctrl.sv
logic/rob_payload_store.sv
logic/rob_status_table.sv
logic/rob_commit_select.sv
logic/rob_top.sv
dv/rob_clk_gen.sv
dv/rob_tb.sv

// File: Makefile
TOP = rob_tb

all: sim

lint:
	verilator --lint-only --timing --assert -f rob.f --top-module $(TOP)

build:
	verilator --binary --assert -Wno-fatal -f rob.f --top-module $(TOP) -o $(TOP)

sim: build
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Something failed" sim.log; then exit 1; fi
	@grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all lint build sim clean

// File: dv/rob_tb.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module rob_tb;

  localparam int NUM_ROWS      = 36;
  localparam int WORDS_PER_ROW = 9;
  localparam int CLK_PERIOD    = 100;

  logic                                           clk;
  logic                                           rst_n;
  logic                                           flush;
  logic [`ROB_ALLOC_WIDTH-1:0]                    alloc_valid;
  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_PC_W-1:0]     alloc_pc;
  logic [`ROB_ALLOC_WIDTH-1:0][1:0]               alloc_type;
  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_AREG_W-1:0]   alloc_areg;
  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_PREG_W-1:0]   alloc_preg;
  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_PREG_W-1:0]   alloc_old_preg;
  logic [`ROB_ALLOC_WIDTH-1:0]                    alloc_excp;
  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_ECODE_W-1:0]  alloc_ecode;
  logic                                           alloc_ready;
  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_IDX_W-1:0]    alloc_idx;
  logic [`ROB_ALLOC_WIDTH-1:0]                    alloc_pos;
  logic [1:0]                                     alu_wb_valid;
  logic [1:0][`ROB_IDX_W-1:0]                     alu_wb_idx;
  logic [1:0]                                     alu_wb_redirect;
  logic [1:0][`ROB_PC_W-1:0]                      alu_wb_target;
  logic                                           mem_wb_valid;
  logic [`ROB_IDX_W-1:0]                          mem_wb_idx;
  logic                                           mem_wb_is_load;
  logic                                           mem_wb_excp;
  logic [`ROB_ECODE_W-1:0]                        mem_wb_ecode;
  logic [`ROB_PC_W-1:0]                           mem_wb_vaddr;
  logic                                           mem_wb_ready;
  logic [`ROB_COMMIT_WIDTH-1:0]                   cmt_valid;
  logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PC_W-1:0]    cmt_pc;
  logic [`ROB_COMMIT_WIDTH-1:0][1:0]              cmt_type;
  logic [`ROB_COMMIT_WIDTH-1:0][`ROB_AREG_W-1:0]  cmt_areg;
  logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PREG_W-1:0]  cmt_preg;
  logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PREG_W-1:0]  cmt_old_preg;
  logic [`ROB_COMMIT_WIDTH-1:0]                   cmt_redirect;
  logic [`ROB_COMMIT_WIDTH-1:0]                   cmt_excp;
  rob_pkg::rob_aux_u [`ROB_COMMIT_WIDTH-1:0]      cmt_aux;

  // one row = ctl, mem, alloc pc, operand, then five expected words
  logic [31:0] patterns [NUM_ROWS*WORDS_PER_ROW];
  int          checks;
  int          errors;

  // reference queue, advanced with the expected flags of each row
  logic [`ROB_IDX_W:0]    ref_head;
  logic [`ROB_IDX_W:0]    ref_tail;
  logic [1:0]             ref_type     [`ROB_DEPTH];
  logic [`ROB_AREG_W-1:0] ref_areg     [`ROB_DEPTH];
  logic [`ROB_PREG_W-1:0] ref_preg     [`ROB_DEPTH];
  logic [`ROB_PREG_W-1:0] ref_old_preg [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0]  ref_redirect;
  logic [`ROB_DEPTH-1:0]  ref_excp;

  rob_clk_gen u_clk_gen (.clk, .rst_n);

  rob_top u_dut (.*);

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp, input int row);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] row %0d %s expected %h got %h", row, name, exp, got);
    end
  endtask

  // ======================================================================
  // row decode and compare
  // ======================================================================
  task automatic apply_row(input int row);
    logic [31:0] ctl;
    logic [31:0] mem;
    logic [31:0] opnd;
    ctl  = patterns[row*WORDS_PER_ROW];
    mem  = patterns[row*WORDS_PER_ROW+1];
    opnd = patterns[row*WORDS_PER_ROW+3];
    flush            = ctl[28];
    alloc_valid      = ctl[25:24];
    alloc_type[0]    = ctl[21:20];
    alloc_type[1]    = ctl[17:16];
    alloc_pc[0]      = patterns[row*WORDS_PER_ROW+2];
    alloc_pc[1]      = patterns[row*WORDS_PER_ROW+2] + 32'd4;
    // register numbers follow the pc so every entry carries its own
    for (int i = 0; i < 2; i++) begin
      alloc_areg[i]     = alloc_pc[i][6:2];
      alloc_preg[i]     = alloc_pc[i][7:2] ^ 6'h2a;
      alloc_old_preg[i] = alloc_pc[i][7:2] ^ 6'h15;
    end
    alu_wb_valid     = ctl[13:12];
    alu_wb_idx[0]    = ctl[11:8];
    alu_wb_idx[1]    = ctl[7:4];
    alu_wb_redirect  = ctl[1:0];
    // one operand serves as branch target and as memory address
    alu_wb_target[0] = opnd;
    alu_wb_target[1] = opnd;
    mem_wb_vaddr     = opnd;
    mem_wb_valid     = mem[28];
    mem_wb_idx       = mem[27:24];
    mem_wb_is_load   = mem[20];
    mem_wb_excp      = mem[16];
    mem_wb_ecode     = mem[13:8];
  endtask

  task automatic check_row(input int row);
    logic [31:0]           flags;
    int                    base;
    logic [`ROB_IDX_W:0]   tail_p1;
    logic [`ROB_IDX_W-1:0] idx;
    base    = row * WORDS_PER_ROW + 4;
    flags   = patterns[base];
    tail_p1 = ref_tail + 1'b1;
    check_word("alloc_ready", {31'd0, alloc_ready}, {31'd0, flags[28]}, row);
    check_word("mem_wb_ready", {31'd0, mem_wb_ready}, {31'd0, flags[24]}, row);
    check_word("cmt_valid", {30'd0, cmt_valid}, {30'd0, flags[21:20]}, row);
    check_word("alloc_idx[0]", 32'(alloc_idx[0]), 32'(ref_tail[`ROB_IDX_W-1:0]), row);
    check_word("alloc_pos[0]", 32'(alloc_pos[0]), 32'(ref_tail[`ROB_IDX_W]), row);
    check_word("alloc_idx[1]", 32'(alloc_idx[1]), 32'(tail_p1[`ROB_IDX_W-1:0]), row);
    check_word("alloc_pos[1]", 32'(alloc_pos[1]), 32'(tail_p1[`ROB_IDX_W]), row);
    // slot fields only mean something when the slot retires
    for (int s = 0; s < 2; s++) begin
      if (flags[20+s]) begin
        idx = ref_head[`ROB_IDX_W-1:0] + 4'(s);
        check_word($sformatf("cmt_pc[%0d]", s), cmt_pc[s], patterns[base+1+2*s], row);
        check_word($sformatf("cmt_aux[%0d]", s), cmt_aux[s], patterns[base+2+2*s], row);
        check_word($sformatf("cmt_type[%0d]", s), 32'(cmt_type[s]),
                   32'(ref_type[idx]), row);
        check_word($sformatf("cmt_areg[%0d]", s), 32'(cmt_areg[s]),
                   32'(ref_areg[idx]), row);
        check_word($sformatf("cmt_preg[%0d]", s), 32'(cmt_preg[s]),
                   32'(ref_preg[idx]), row);
        check_word($sformatf("cmt_old_preg[%0d]", s), 32'(cmt_old_preg[s]),
                   32'(ref_old_preg[idx]), row);
        check_word($sformatf("cmt_redirect[%0d]", s), 32'(cmt_redirect[s]),
                   32'(ref_redirect[idx]), row);
        check_word($sformatf("cmt_excp[%0d]", s), 32'(cmt_excp[s]),
                   32'(ref_excp[idx]), row);
      end
    end
  endtask

  // state the reference queue takes at the coming edge
  task automatic advance_ref(input int row);
    logic [31:0]           flags;
    logic [`ROB_IDX_W-1:0] idx;
    flags = patterns[row*WORDS_PER_ROW+4];
    if (flush) begin
      ref_head = '0;
      ref_tail = '0;
    end else begin
      if (flags[28]) begin
        for (int i = 0; i < 2; i++) begin
          if (alloc_valid[i]) begin
            idx               = ref_tail[`ROB_IDX_W-1:0] + 4'(i);
            ref_type[idx]     = alloc_type[i];
            ref_areg[idx]     = alloc_areg[i];
            ref_preg[idx]     = alloc_preg[i];
            ref_old_preg[idx] = alloc_old_preg[i];
            ref_redirect[idx] = 1'b0;
            ref_excp[idx]     = alloc_excp[i];
          end
        end
        ref_tail = ref_tail + {4'd0, alloc_valid[0]} + {4'd0, alloc_valid[1]};
      end
      for (int i = 0; i < 2; i++) begin
        if (alu_wb_valid[i]) begin
          ref_redirect[alu_wb_idx[i]] = alu_wb_redirect[i];
        end
      end
      if (mem_wb_valid && flags[24]) begin
        ref_excp[mem_wb_idx] = mem_wb_excp;
      end
      ref_head = ref_head + {4'd0, flags[20]} + {4'd0, flags[21]};
    end
  endtask

  initial begin
    checks          = 0;
    errors          = 0;
    ref_head        = '0;
    ref_tail        = '0;
    ref_redirect    = '0;
    ref_excp        = '0;
    flush           = 1'b0;
    alloc_valid     = '0;
    alloc_pc        = '0;
    alloc_type      = '0;
    alloc_areg      = {5'd2, 5'd1};
    alloc_preg      = {6'd34, 6'd33};
    alloc_old_preg  = {6'd2, 6'd1};
    alloc_excp      = '0;
    alloc_ecode     = '0;
    alu_wb_valid    = '0;
    alu_wb_idx      = '0;
    alu_wb_redirect = '0;
    alu_wb_target   = '0;
    mem_wb_valid    = 1'b0;
    mem_wb_idx      = '0;
    mem_wb_is_load  = 1'b0;
    mem_wb_excp     = 1'b0;
    mem_wb_ecode    = '0;
    mem_wb_vaddr    = '0;
    for (int i = 0; i < NUM_ROWS*WORDS_PER_ROW; i++) begin
      patterns[i] = {16'hbad0, 16'(i)};
    end
    $readmemh("dv/rob_patterns.hex", patterns);
    if (patterns[NUM_ROWS*WORDS_PER_ROW-1][31:16] == 16'hbad0) begin
      errors++;
      $display("pattern file is missing or shorter than %0d rows", NUM_ROWS);
    end
    wait (rst_n === 1'b1);
    if (errors == 0) begin
      for (int row = 0; row < NUM_ROWS; row++) begin
        @(posedge clk);
        #1;
        apply_row(row);
        #(CLK_PERIOD - 3);
        check_row(row);
        advance_ref(row);
      end
    end
    @(posedge clk);
    #1;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // reset, every row, and some slack
  initial begin
    #((NUM_ROWS + 16 + 20) * CLK_PERIOD);
    $display("timeout, the pattern run did not reach its end");
    $display("Something failed");
    $finish;
  end

endmodule

// File: dv/rob_clk_gen.sv
`timescale 1ns/1ps

module rob_clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // released on a falling edge, clear of the rising edges
  initial begin
    rst_n = 1'b0;
    #(RESET_CYCLES * 2 * HALF_PERIOD);
    rst_n = 1'b1;
  end

endmodule

// File: logic/rob_top.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module rob_top (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic                                           flush,
  // allocation
  input  logic [`ROB_ALLOC_WIDTH-1:0]                    alloc_valid,
  input  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_PC_W-1:0]     alloc_pc,
  input  logic [`ROB_ALLOC_WIDTH-1:0][1:0]               alloc_type,
  input  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_AREG_W-1:0]   alloc_areg,
  input  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_PREG_W-1:0]   alloc_preg,
  input  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_PREG_W-1:0]   alloc_old_preg,
  input  logic [`ROB_ALLOC_WIDTH-1:0]                    alloc_excp,
  input  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_ECODE_W-1:0]  alloc_ecode,
  output logic                                           alloc_ready,
  output logic [`ROB_ALLOC_WIDTH-1:0][`ROB_IDX_W-1:0]    alloc_idx,
  output logic [`ROB_ALLOC_WIDTH-1:0]                    alloc_pos,
  // write-back
  input  logic [1:0]                                     alu_wb_valid,
  input  logic [1:0][`ROB_IDX_W-1:0]                     alu_wb_idx,
  input  logic [1:0]                                     alu_wb_redirect,
  input  logic [1:0][`ROB_PC_W-1:0]                      alu_wb_target,
  input  logic                                           mem_wb_valid,
  input  logic [`ROB_IDX_W-1:0]                          mem_wb_idx,
  input  logic                                           mem_wb_is_load,
  input  logic                                           mem_wb_excp,
  input  logic [`ROB_ECODE_W-1:0]                        mem_wb_ecode,
  input  logic [`ROB_PC_W-1:0]                           mem_wb_vaddr,
  output logic                                           mem_wb_ready,
  // commit
  output logic [`ROB_COMMIT_WIDTH-1:0]                   cmt_valid,
  output logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PC_W-1:0]    cmt_pc,
  output logic [`ROB_COMMIT_WIDTH-1:0][1:0]              cmt_type,
  output logic [`ROB_COMMIT_WIDTH-1:0][`ROB_AREG_W-1:0]  cmt_areg,
  output logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PREG_W-1:0]  cmt_preg,
  output logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PREG_W-1:0]  cmt_old_preg,
  output logic [`ROB_COMMIT_WIDTH-1:0]                   cmt_redirect,
  output logic [`ROB_COMMIT_WIDTH-1:0]                   cmt_excp,
  output rob_pkg::rob_aux_u [`ROB_COMMIT_WIDTH-1:0]      cmt_aux
);

  logic [`ROB_IDX_W-1:0]                          head_idx;
  logic [`ROB_IDX_W-1:0]                          tail_idx;
  logic [`ROB_IDX_W:0]                            rob_count;
  logic [1:0]                                     commit_cnt;
  logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PC_W-1:0]    hd_pc;
  logic [`ROB_COMMIT_WIDTH-1:0][1:0]              hd_type;
  logic [`ROB_COMMIT_WIDTH-1:0][`ROB_AREG_W-1:0]  hd_areg;
  logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PREG_W-1:0]  hd_preg;
  logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PREG_W-1:0]  hd_old_preg;
  logic [`ROB_COMMIT_WIDTH-1:0]                   hd_complete;
  logic [`ROB_COMMIT_WIDTH-1:0]                   hd_redirect;
  logic [`ROB_COMMIT_WIDTH-1:0]                   hd_excp;
  rob_pkg::rob_aux_u [`ROB_COMMIT_WIDTH-1:0]      hd_aux;

  rob_queue_ctrl u_queue_ctrl (
    .clk, .rst_n, .flush, .alloc_valid, .commit_cnt,
    .alloc_ready, .alloc_idx, .alloc_pos, .tail_idx, .head_idx, .rob_count
  );

  rob_payload_store u_payload_store (
    .clk, .alloc_ready, .alloc_valid, .tail_idx,
    .alloc_pc, .alloc_type, .alloc_areg, .alloc_preg, .alloc_old_preg, .head_idx,
    .hd_pc, .hd_type, .hd_areg, .hd_preg, .hd_old_preg
  );

  rob_status_table u_status_table (
    .clk, .rst_n, .alloc_ready, .alloc_valid, .alloc_excp, .alloc_ecode,
    .tail_idx, .alloc_pc,
    .alu_wb_valid, .alu_wb_idx, .alu_wb_redirect, .alu_wb_target,
    .mem_wb_valid, .mem_wb_idx, .mem_wb_is_load, .mem_wb_excp,
    .mem_wb_ecode, .mem_wb_vaddr, .head_idx,
    .mem_wb_ready, .hd_complete, .hd_redirect, .hd_excp, .hd_aux
  );

  rob_commit_select u_commit_select (
    .rob_count, .hd_type, .hd_complete, .hd_redirect, .hd_excp, .hd_aux,
    .hd_pc, .hd_areg, .hd_preg, .hd_old_preg,
    .cmt_valid, .cmt_pc, .cmt_type, .cmt_areg, .cmt_preg, .cmt_old_preg,
    .cmt_redirect, .cmt_excp, .cmt_aux, .commit_cnt
  );

endmodule

// File: logic/rob_commit_select.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module rob_commit_select (
  input  logic [`ROB_IDX_W:0]                           rob_count,
  input  logic [`ROB_COMMIT_WIDTH-1:0][1:0]             hd_type,
  input  logic [`ROB_COMMIT_WIDTH-1:0]                  hd_complete,
  input  logic [`ROB_COMMIT_WIDTH-1:0]                  hd_redirect,
  input  logic [`ROB_COMMIT_WIDTH-1:0]                  hd_excp,
  input  rob_pkg::rob_aux_u [`ROB_COMMIT_WIDTH-1:0]     hd_aux,
  input  logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PC_W-1:0]   hd_pc,
  input  logic [`ROB_COMMIT_WIDTH-1:0][`ROB_AREG_W-1:0] hd_areg,
  input  logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PREG_W-1:0] hd_preg,
  input  logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PREG_W-1:0] hd_old_preg,
  output logic [`ROB_COMMIT_WIDTH-1:0]                  cmt_valid,
  output logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PC_W-1:0]   cmt_pc,
  output logic [`ROB_COMMIT_WIDTH-1:0][1:0]             cmt_type,
  output logic [`ROB_COMMIT_WIDTH-1:0][`ROB_AREG_W-1:0] cmt_areg,
  output logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PREG_W-1:0] cmt_preg,
  output logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PREG_W-1:0] cmt_old_preg,
  output logic [`ROB_COMMIT_WIDTH-1:0]                  cmt_redirect,
  output logic [`ROB_COMMIT_WIDTH-1:0]                  cmt_excp,
  output rob_pkg::rob_aux_u [`ROB_COMMIT_WIDTH-1:0]     cmt_aux,
  output logic [1:0]                                    commit_cnt
);

  logic slot1_flush;
  logic both_br;

  // redirect or exception in slot 1 drains the pipe before it retires
  assign slot1_flush = hd_redirect[1] || hd_excp[1];
  // predictor takes a single branch update per cycle
  assign both_br = (hd_type[0] == `ROB_TYPE_BR) && (hd_type[1] == `ROB_TYPE_BR);

  assign cmt_valid[0] = (rob_count >= 1) && hd_complete[0];
  assign cmt_valid[1] = cmt_valid[0] && (rob_count >= 2) && hd_complete[1] &&
                        !slot1_flush && !both_br;

  assign commit_cnt = {1'b0, cmt_valid[0]} + {1'b0, cmt_valid[1]};

  // entry fields straight from the head slots
  assign cmt_pc       = hd_pc;
  assign cmt_type     = hd_type;
  assign cmt_areg     = hd_areg;
  assign cmt_preg     = hd_preg;
  assign cmt_old_preg = hd_old_preg;
  assign cmt_redirect = hd_redirect;
  assign cmt_excp     = hd_excp;
  assign cmt_aux      = hd_aux;

endmodule

// File: logic/rob_status_table.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module rob_status_table (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic                                           alloc_ready,
  input  logic [`ROB_ALLOC_WIDTH-1:0]                    alloc_valid,
  input  logic [`ROB_ALLOC_WIDTH-1:0]                    alloc_excp,
  input  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_ECODE_W-1:0]  alloc_ecode,
  input  logic [`ROB_IDX_W-1:0]                          tail_idx,
  input  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_PC_W-1:0]     alloc_pc,
  input  logic [1:0]                                     alu_wb_valid,
  input  logic [1:0][`ROB_IDX_W-1:0]                     alu_wb_idx,
  input  logic [1:0]                                     alu_wb_redirect,
  input  logic [1:0][`ROB_PC_W-1:0]                      alu_wb_target,
  input  logic                                           mem_wb_valid,
  input  logic [`ROB_IDX_W-1:0]                          mem_wb_idx,
  input  logic                                           mem_wb_is_load,
  input  logic                                           mem_wb_excp,
  input  logic [`ROB_ECODE_W-1:0]                        mem_wb_ecode,
  input  logic [`ROB_PC_W-1:0]                           mem_wb_vaddr,
  input  logic [`ROB_IDX_W-1:0]                          head_idx,
  output logic                                           mem_wb_ready,
  output logic [`ROB_COMMIT_WIDTH-1:0]                   hd_complete,
  output logic [`ROB_COMMIT_WIDTH-1:0]                   hd_redirect,
  output logic [`ROB_COMMIT_WIDTH-1:0]                   hd_excp,
  output rob_pkg::rob_aux_u [`ROB_COMMIT_WIDTH-1:0]      hd_aux
);

  logic [`ROB_DEPTH-1:0] complete_q;
  logic [`ROB_DEPTH-1:0] redirect_q;
  logic [`ROB_DEPTH-1:0] excp_q;
  rob_pkg::rob_aux_u     aux_q [`ROB_DEPTH];

  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_IDX_W-1:0]  wr_idx;
  logic [`ROB_COMMIT_WIDTH-1:0][`ROB_IDX_W-1:0] rd_idx;
  rob_pkg::rob_aux_u [`ROB_ALLOC_WIDTH-1:0]     fe_aux;
  rob_pkg::rob_aux_u                            mem_aux;
  logic                                         mem_acc;

  assign wr_idx[0] = tail_idx;
  assign wr_idx[1] = tail_idx + 1'b1;
  assign rd_idx[0] = head_idx;
  assign rd_idx[1] = head_idx + 1'b1;

  // stores and other side effects wait until they are the oldest
  assign mem_wb_ready = mem_wb_is_load || (mem_wb_idx == head_idx);
  assign mem_acc      = mem_wb_valid && mem_wb_ready;

  // exception words for front-end faults and memory faults
  always_comb begin
    for (int i = 0; i < `ROB_ALLOC_WIDTH; i++) begin
      fe_aux[i].excp.ecode   = alloc_ecode[i];
      fe_aux[i].excp.badv_hi = alloc_pc[i][`ROB_PC_W-1:`ROB_ECODE_W];
    end
    mem_aux.excp.ecode   = mem_wb_ecode;
    mem_aux.excp.badv_hi = mem_wb_vaddr[`ROB_PC_W-1:`ROB_ECODE_W];
  end

  // ======================================================================
  // allocation, then write-back
  // ======================================================================
  always_ff @(posedge clk) begin
    for (int i = 0; i < `ROB_ALLOC_WIDTH; i++) begin
      if (alloc_ready && alloc_valid[i]) begin
        // a front-end fault needs no execution
        complete_q[wr_idx[i]] <= alloc_excp[i];
        redirect_q[wr_idx[i]] <= 1'b0;
        excp_q[wr_idx[i]]     <= alloc_excp[i];
        aux_q[wr_idx[i]]      <= fe_aux[i];
      end
    end
    for (int i = 0; i < 2; i++) begin
      if (alu_wb_valid[i]) begin
        complete_q[alu_wb_idx[i]]      <= 1'b1;
        redirect_q[alu_wb_idx[i]]      <= alu_wb_redirect[i];
        aux_q[alu_wb_idx[i]].br_target <= alu_wb_target[i];
      end
    end
    if (mem_acc) begin
      complete_q[mem_wb_idx] <= 1'b1;
      excp_q[mem_wb_idx]     <= mem_wb_excp;
      aux_q[mem_wb_idx]      <= mem_aux;
    end
  end

  always_comb begin
    for (int j = 0; j < `ROB_COMMIT_WIDTH; j++) begin
      hd_complete[j] = complete_q[rd_idx[j]];
      hd_redirect[j] = redirect_q[rd_idx[j]];
      hd_excp[j]     = excp_q[rd_idx[j]];
      hd_aux[j]      = aux_q[rd_idx[j]];
    end
  end

  // each instruction finishes on exactly one port
  a_wb_idx_unique: assert property (@(posedge clk) disable iff (!rst_n)
    !(alu_wb_valid[0] && alu_wb_valid[1] && alu_wb_idx[0] == alu_wb_idx[1]) &&
    !(mem_acc && alu_wb_valid[0] && alu_wb_idx[0] == mem_wb_idx) &&
    !(mem_acc && alu_wb_valid[1] && alu_wb_idx[1] == mem_wb_idx));

endmodule

// File: logic/rob_payload_store.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module rob_payload_store (
  input  logic                                          clk,
  input  logic                                          alloc_ready,
  input  logic [`ROB_ALLOC_WIDTH-1:0]                   alloc_valid,
  input  logic [`ROB_IDX_W-1:0]                         tail_idx,
  input  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_PC_W-1:0]    alloc_pc,
  input  logic [`ROB_ALLOC_WIDTH-1:0][1:0]              alloc_type,
  input  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_AREG_W-1:0]  alloc_areg,
  input  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_PREG_W-1:0]  alloc_preg,
  input  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_PREG_W-1:0]  alloc_old_preg,
  input  logic [`ROB_IDX_W-1:0]                         head_idx,
  output logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PC_W-1:0]   hd_pc,
  output logic [`ROB_COMMIT_WIDTH-1:0][1:0]             hd_type,
  output logic [`ROB_COMMIT_WIDTH-1:0][`ROB_AREG_W-1:0] hd_areg,
  output logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PREG_W-1:0] hd_preg,
  output logic [`ROB_COMMIT_WIDTH-1:0][`ROB_PREG_W-1:0] hd_old_preg
);

  // static fields, written once per allocation
  logic [`ROB_PC_W-1:0]   pc_q       [`ROB_DEPTH];
  logic [1:0]             type_q     [`ROB_DEPTH];
  logic [`ROB_AREG_W-1:0] areg_q     [`ROB_DEPTH];
  logic [`ROB_PREG_W-1:0] preg_q     [`ROB_DEPTH];
  logic [`ROB_PREG_W-1:0] old_preg_q [`ROB_DEPTH];

  logic [`ROB_ALLOC_WIDTH-1:0][`ROB_IDX_W-1:0]  wr_idx;
  logic [`ROB_COMMIT_WIDTH-1:0][`ROB_IDX_W-1:0] rd_idx;

  // index arithmetic wraps at the depth
  assign wr_idx[0] = tail_idx;
  assign wr_idx[1] = tail_idx + 1'b1;
  assign rd_idx[0] = head_idx;
  assign rd_idx[1] = head_idx + 1'b1;

  always_ff @(posedge clk) begin
    for (int i = 0; i < `ROB_ALLOC_WIDTH; i++) begin
      if (alloc_ready && alloc_valid[i]) begin
        pc_q[wr_idx[i]]       <= alloc_pc[i];
        type_q[wr_idx[i]]     <= alloc_type[i];
        areg_q[wr_idx[i]]     <= alloc_areg[i];
        preg_q[wr_idx[i]]     <= alloc_preg[i];
        old_preg_q[wr_idx[i]] <= alloc_old_preg[i];
      end
    end
  end

  // head and head+1
  always_comb begin
    for (int j = 0; j < `ROB_COMMIT_WIDTH; j++) begin
      hd_pc[j]       = pc_q[rd_idx[j]];
      hd_type[j]     = type_q[rd_idx[j]];
      hd_areg[j]     = areg_q[rd_idx[j]];
      hd_preg[j]     = preg_q[rd_idx[j]];
      hd_old_preg[j] = old_preg_q[rd_idx[j]];
    end
  end

endmodule

// File: logic/rob_queue_ctrl.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module rob_queue_ctrl (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        flush,
  input  logic [`ROB_ALLOC_WIDTH-1:0]                 alloc_valid,
  input  logic [1:0]                                  commit_cnt,
  output logic                                        alloc_ready,
  output logic [`ROB_ALLOC_WIDTH-1:0][`ROB_IDX_W-1:0] alloc_idx,
  output logic [`ROB_ALLOC_WIDTH-1:0]                 alloc_pos,
  output logic [`ROB_IDX_W-1:0]                       tail_idx,
  output logic [`ROB_IDX_W-1:0]                       head_idx,
  output logic [`ROB_IDX_W:0]                         rob_count
);

  // pointers carry the position bit on top of the index
  logic [`ROB_IDX_W:0] head_ptr;
  logic [`ROB_IDX_W:0] tail_ptr;
  logic [`ROB_IDX_W:0] tail_ptr_p1;
  logic [1:0]          alloc_cnt;

  // room for a full allocation group
  assign alloc_ready = rob_count <= (`ROB_DEPTH - `ROB_ALLOC_WIDTH);
  assign alloc_cnt   = {1'b0, alloc_valid[0]} + {1'b0, alloc_valid[1]};
  assign tail_ptr_p1 = tail_ptr + 1'b1;

  assign alloc_idx[0] = tail_ptr[`ROB_IDX_W-1:0];
  assign alloc_pos[0] = tail_ptr[`ROB_IDX_W];
  assign alloc_idx[1] = tail_ptr_p1[`ROB_IDX_W-1:0];
  assign alloc_pos[1] = tail_ptr_p1[`ROB_IDX_W];

  assign tail_idx = tail_ptr[`ROB_IDX_W-1:0];
  assign head_idx = head_ptr[`ROB_IDX_W-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_ptr  <= '0;
      tail_ptr  <= '0;
      rob_count <= '0;
    end else if (flush) begin
      head_ptr  <= '0;
      tail_ptr  <= '0;
      rob_count <= '0;
    end else begin
      head_ptr  <= head_ptr + commit_cnt;
      if (alloc_ready) begin
        tail_ptr <= tail_ptr + alloc_cnt;
      end
      rob_count <= rob_count + (alloc_ready ? alloc_cnt : 2'd0) - commit_cnt;
    end
  end

  // ======================================================================
  // checks
  // ======================================================================
  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    rob_count <= `ROB_DEPTH);

  // occupancy agrees with the pointer distance
  a_count_matches_ptrs: assert property (@(posedge clk) disable iff (!rst_n)
    rob_count == tail_ptr - head_ptr);

  // commit selector never retires more than is queued
  a_commit_le_count: assert property (@(posedge clk) disable iff (!rst_n)
    commit_cnt <= rob_count);

endmodule

// File: logic/rob_pkg.sv
`include "rob_config.svh"

package rob_pkg;

  // ======================================================================
  // auxiliary word, one per entry
  // ======================================================================

  // exception view
  // the low bits of the bad address are dropped to make room for the code
  typedef struct packed {
    logic [`ROB_ECODE_W-1:0]             ecode;
    logic [`ROB_PC_W-`ROB_ECODE_W-1:0]   badv_hi;
  } rob_excp_t;

  // redirect flag set -> br_target is meaningful
  // exception flag set -> excp is meaningful
  typedef union packed {
    logic [`ROB_PC_W-1:0] br_target;
    rob_excp_t            excp;
  } rob_aux_u;

endpackage

// File: logic/rob_config.svh
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// queue geometry
`define ROB_DEPTH        16
`define ROB_IDX_W        4
`define ROB_ALLOC_WIDTH  2
`define ROB_COMMIT_WIDTH 2

// field widths
`define ROB_PC_W    32
`define ROB_AREG_W  5
`define ROB_PREG_W  6
`define ROB_ECODE_W 6

// instruction types
`define ROB_TYPE_ALU   2'd0
`define ROB_TYPE_BR    2'd1
`define ROB_TYPE_LOAD  2'd2
`define ROB_TYPE_STORE 2'd3

`endif
